//--- include/crop_cfg.svh
`ifndef CROP_CFG_SVH
`define CROP_CFG_SVH

// counters, sizes and offsets all share one width
`define COORD_W 12
`define FLAG_W  7   // mode change counter

// offset change per key press
`define H_STEP 4
`define V_STEP 1

// keyboard codes as delivered by the host
`define KEY_CLEAR    8'h41  // backspace
`define KEY_UP       8'h4c
`define KEY_DOWN     8'h4d
`define KEY_LEFT     8'h4f
`define KEY_RIGHT    8'h4e
`define KEY_ALT_L    8'h64
`define KEY_ALT_R    8'h65
`define KEY_ALT_L_UP 8'he4
`define KEY_ALT_R_UP 8'he5
`define KEY_TYPE_KBD 2'd3

// wishbone register map
`define WB_ADR_W   3
`define REG_HSIZE  3'd0
`define REG_VSIZE  3'd1
`define REG_HOFS   3'd2
`define REG_VOFS   3'd3
`define REG_STATUS 3'd4

`endif

//--- verilog/video_pkg.sv
`include "crop_cfg.svh"

package video_pkg;

	typedef logic [`COORD_W-1:0] coord_t;

	// timing from the emulated source, all active high
	typedef struct packed {
		logic       hsync;
		logic       vsync;
		logic       hblank;
		logic       vblank;
		logic [1:0] res;    // resolution select of the source
	} video_sync_t;

	// measured active area
	typedef struct packed {
		coord_t hsize;
		coord_t vsize;
	} geometry_t;

	// amount trimmed from each edge of the active area
	typedef struct packed {
		coord_t left;
		coord_t right;
		coord_t top;
		coord_t bottom;
	} border_t;

endpackage

//--- verilog/host_pkg.sv
`include "crop_cfg.svh"

package host_pkg;

	// wishbone classic, master side
	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [`WB_ADR_W-1:0] adr;
		logic [31:0]          dat;
	} wb_req_t;

	// wishbone classic, slave side
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// keyboard/mouse event from the host
	// a new event is signalled by a toggle of level
	typedef struct packed {
		logic       level;
		logic [1:0] kind;   // event source, keyboard or mouse
		logic [7:0] data;   // key code
	} key_event_t;

endpackage

//--- verilog/border_ctrl.sv
`timescale 1ns/1ps
`include "crop_cfg.svh"

module border_ctrl (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  host_pkg::key_event_t  key,
	input  host_pkg::wb_req_t     wb_req,
	output host_pkg::wb_rsp_t     wb_rsp,
	input  video_pkg::coord_t     hsize,
	input  video_pkg::coord_t     vsize,
	input  logic [`FLAG_W-1:0]    mode_count,
	output video_pkg::border_t    border
);
	import video_pkg::*;

	logic        old_level;
	logic        alt;       // alt held, arrows move right/bottom
	logic        key_hit;
	logic        wb_hit;
	logic        ack_q;
	logic [31:0] dat_q;
	logic [31:0] rd_data;

	assign key_hit = (key.level ^ old_level) && (key.kind == `KEY_TYPE_KBD);
	assign wb_hit  = wb_req.cyc & wb_req.stb & ~ack_q; // one ack per request

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_level <= 1'b0;
			alt <= 1'b0;
			border <= '0;
		end else begin
			old_level <= key.level;
			if (key_hit) begin
				case (key.data)
					`KEY_CLEAR: border <= '0;
					`KEY_UP: begin
						if (alt)
							border.bottom <= border.bottom + coord_t'(`V_STEP);
						else
							border.top <= border.top + coord_t'(`V_STEP);
					end
					`KEY_DOWN: begin
						if (alt)
							border.bottom <= border.bottom - coord_t'(`V_STEP);
						else
							border.top <= border.top - coord_t'(`V_STEP);
					end
					`KEY_LEFT: begin
						if (alt)
							border.right <= border.right + coord_t'(`H_STEP);
						else
							border.left <= border.left + coord_t'(`H_STEP);
					end
					`KEY_RIGHT: begin
						if (alt)
							border.right <= border.right - coord_t'(`H_STEP);
						else
							border.left <= border.left - coord_t'(`H_STEP);
					end
					`KEY_ALT_L, `KEY_ALT_R:       alt <= 1'b1;
					`KEY_ALT_L_UP, `KEY_ALT_R_UP: alt <= 1'b0;
					default: ;                    // other keys pass by
				endcase
			end

			// host write overrides a key step on the same pair
			if (wb_hit && wb_req.we) begin
				case (wb_req.adr)
					`REG_HOFS: begin
						border.left  <= wb_req.dat[`COORD_W-1:0];
						border.right <= wb_req.dat[16 +: `COORD_W];
					end
					`REG_VOFS: begin
						border.top    <= wb_req.dat[`COORD_W-1:0];
						border.bottom <= wb_req.dat[16 +: `COORD_W];
					end
					default: ;  // measurements and status are read only
				endcase
			end
		end
	end

	always_comb begin
		case (wb_req.adr)
			`REG_HSIZE:  rd_data = 32'(hsize);
			`REG_VSIZE:  rd_data = 32'(vsize);
			`REG_HOFS:   rd_data = {16'(border.right), 16'(border.left)};
			`REG_VOFS:   rd_data = {16'(border.bottom), 16'(border.top)};
			`REG_STATUS: rd_data = 32'(mode_count);
			default:     rd_data = '0;
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			ack_q <= 1'b0;
		else
			ack_q <= wb_hit;
	end

	always_ff @(posedge clk_sys) begin
		if (wb_hit)
			dat_q <= rd_data;
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = dat_q;

endmodule

//--- verilog/line_timer.sv
`timescale 1ns/1ps

module line_timer (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  video_pkg::video_sync_t video,
	input  video_pkg::border_t     border,
	output logic                   line_start,
	output video_pkg::coord_t      hsize,
	output logic                   hde
);
	import video_pkg::*;

	coord_t hcnt;        // zero during hsync
	coord_t hend;        // count where hblank ends
	coord_t hsta;        // count where hblank starts
	logic   old_hsync;
	logic   old_hblank;
	logic   hbl_fall;
	logic   hbl_rise;

	assign line_start = video.hsync & ~old_hsync;
	assign hbl_fall   = old_hblank & ~video.hblank;
	assign hbl_rise   = ~old_hblank & video.hblank;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hsync <= 1'b0;
			old_hblank <= 1'b0;
			hcnt <= '0;
			hend <= '0;
			hsta <= '0;
			hsize <= '0;
			hde <= 1'b0;
		end else begin
			old_hsync <= video.hsync;
			old_hblank <= video.hblank;

			if (video.hsync)
				hcnt <= '0;
			else
				hcnt <= hcnt + 1'b1;

			if (hbl_fall)
				hend <= hcnt;
			if (hbl_rise) begin
				hsta <= hcnt;
				hsize <= hcnt - hend;
			end

			// trimmed window uses the previous line's edges
			if (hcnt == hend + border.left)
				hde <= 1'b1;
			if (hcnt == hsta - border.right)
				hde <= 1'b0;     // wins when the window is empty
		end
	end

endmodule

//--- verilog/frame_timer.sv
`timescale 1ns/1ps

module frame_timer (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  video_pkg::video_sync_t video,
	input  logic                   line_start,
	input  video_pkg::border_t     border,
	output logic                   frame_start,
	output video_pkg::coord_t      vsize,
	output logic                   vde
);
	import video_pkg::*;

	coord_t lcnt;        // lines since vblank began
	coord_t line_next;   // number of the line being started
	coord_t vend;        // line where vblank ends
	coord_t vmax;        // line where vblank starts
	logic   old_vblank;
	logic   vbl_rise;
	logic   ven;

	assign line_next   = lcnt + 1'b1;
	assign vbl_rise    = video.vblank & ~old_vblank;
	assign frame_start = old_vblank & ~video.vblank;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vblank <= 1'b0;
			lcnt <= '0;
			vend <= '0;
			vmax <= '0;
			vsize <= '0;
			ven <= 1'b0;
			vde <= 1'b0;
		end else begin
			old_vblank <= video.vblank;

			if (line_start)
				lcnt <= line_next;

			// vblank edges are expected away from the hsync edge
			if (vbl_rise) begin
				lcnt <= '0;
				vmax <= lcnt;
				vsize <= lcnt - vend;
			end
			if (frame_start)
				vend <= lcnt;

			// window from the previous frame's edges, checked once per line
			if (line_start) begin
				if (line_next == vend + border.top)
					ven <= 1'b1;
				if (line_next == vmax - border.bottom)
					ven <= 1'b0;
			end

			vde <= ven;
		end
	end

endmodule

//--- verilog/mode_monitor.sv
`timescale 1ns/1ps
`include "crop_cfg.svh"

module mode_monitor (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               frame_start,
	input  video_pkg::coord_t  hsize,
	input  video_pkg::coord_t  vsize,
	input  logic [1:0]         res,
	output logic [`FLAG_W-1:0] mode_count
);
	import video_pkg::*;

	geometry_t  cur_geom;
	geometry_t  snap_geom;  // geometry seen at the last frame start
	logic [1:0] snap_res;
	logic       changed;

	assign cur_geom.hsize = hsize;
	assign cur_geom.vsize = vsize;
	assign changed = (cur_geom != snap_geom) || (res != snap_res);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			snap_geom <= '0;
			snap_res <= '0;
			mode_count <= '0;
		end else if (frame_start) begin
			snap_geom <= cur_geom;
			snap_res <= res;
			if (changed)
				mode_count <= mode_count + 1'b1; // wraps at 128
		end
	end

endmodule

//--- verilog/crop_top.sv
`timescale 1ns/1ps
`include "crop_cfg.svh"

module crop_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  video_pkg::video_sync_t video,
	input  host_pkg::key_event_t   key,
	input  host_pkg::wb_req_t      wb_req,
	output host_pkg::wb_rsp_t      wb_rsp,
	output logic                   hde,
	output logic                   vde
);
	import video_pkg::*;

	border_t            border;
	coord_t             hsize;
	coord_t             vsize;
	logic               line_start;
	logic               frame_start;
	logic [`FLAG_W-1:0] mode_count;

	// offsets and host registers
	border_ctrl border_ctrl0 (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.key        (key),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.hsize      (hsize),
		.vsize      (vsize),
		.mode_count (mode_count),
		.border     (border)
	);

	line_timer line_timer0 (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.video      (video),
		.border     (border),
		.line_start (line_start),
		.hsize      (hsize),
		.hde        (hde)
	);

	frame_timer frame_timer0 (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.video       (video),
		.line_start  (line_start),
		.border      (border),
		.frame_start (frame_start),
		.vsize       (vsize),
		.vde         (vde)
	);

	mode_monitor mode_monitor0 (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.frame_start (frame_start),
		.hsize       (hsize),
		.vsize       (vsize),
		.res         (video.res),
		.mode_count  (mode_count)
	);

endmodule

//--- test/crop_assertions.sv
`timescale 1ns/1ps

module crop_assertions (
	input logic              clk_sys,
	input logic              reset,
	input host_pkg::wb_req_t wb_req,
	input host_pkg::wb_rsp_t wb_rsp,
	input logic              hde,
	input logic              vde
);

	// ack answers a request seen one cycle earlier
	ack_after_request: assert property (@(posedge clk_sys) disable iff (reset)
		wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
		else $error("ack raised without a request in the previous cycle");

	ack_single_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		wb_rsp.ack |=> !wb_rsp.ack)
		else $error("ack held high for two cycles");

	// enables come out of reset low
	enables_low_after_reset: assert property (@(posedge clk_sys)
		$fell(reset) |-> (!hde && !vde))
		else $error("hde or vde high right after reset release");

endmodule

bind crop_top crop_assertions asrt0 (
	.clk_sys (clk_sys),
	.reset   (reset),
	.wb_req  (wb_req),
	.wb_rsp  (wb_rsp),
	.hde     (hde),
	.vde     (vde)
);

//--- test/crop_tb.sv
`timescale 1ns/1ps
`include "crop_cfg.svh"

module crop_tb;
	import video_pkg::*;
	import host_pkg::*;

	// worst frame is 40 lines of 140 cycles, about 25 frames are run
	localparam int PLANNED_FRAMES = 30;
	localparam int TIMEOUT_CYCLES = PLANNED_FRAMES * 40 * 140;

	typedef struct {
		int         len;    // cycles per line
		int         sync;   // hsync width
		int         a;      // first active cycle
		int         b;      // first cycle of hblank after the active part
		int         lines;  // lines per frame
		int         vtop;   // vblank lines at the frame start
		logic [1:0] res;
	} geom_t;

	logic         clk_sys;
	logic         reset;
	video_sync_t  video;
	key_event_t   key;
	wb_req_t      wb_req;
	wb_rsp_t      wb_rsp;
	logic         hde;
	logic         vde;

	logic [31:0]  lfsr = 32'h2848_cb1c;
	geom_t        nxt;
	bit           gen_run;
	bit           trim_chk;
	int           frame_no;
	logic [11:0]  m_left, m_right, m_top, m_bottom;
	logic         m_alt;
	logic [6:0]   exp_mode;

	crop_top dut0 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.video   (video),
		.key     (key),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.hde     (hde),
		.vde     (vde)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'(take_bits(8)) % (hi - lo + 1);
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Error in %s: expected %0h, actual %0h", name, exp, act);
			$display("ERRORS FOUND");
			$fatal(1, "check failed");
		end
	endtask

	task automatic pick_geometry(output geom_t g);
		g.len = rand_range(80, 140);
		g.sync = rand_range(4, 11);
		g.a = g.sync + rand_range(4, 11);
		g.b = g.len - rand_range(2, 17);
		g.lines = rand_range(20, 40);
		g.vtop = rand_range(2, 5);
		g.res = 2'(take_bits(2));
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frame_no + n;
		wait (frame_no >= target);
	endtask

	// one classic cycle, request held until ack
	task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat);
		@(posedge clk_sys);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		forever begin
			@(negedge clk_sys);
			if (wb_rsp.ack)
				break;
		end
		rdat = wb_rsp.dat;
		@(posedge clk_sys);
		wb_req <= '0;
	endtask

	task automatic apply_key_model(input logic [1:0] kind, input logic [7:0] code);
		if (kind == `KEY_TYPE_KBD) begin
			case (code)
				`KEY_CLEAR: {m_left, m_right, m_top, m_bottom} = '0;
				`KEY_UP:    if (m_alt) m_bottom = m_bottom + 12'(`V_STEP);
				            else m_top = m_top + 12'(`V_STEP);
				`KEY_DOWN:  if (m_alt) m_bottom = m_bottom - 12'(`V_STEP);
				            else m_top = m_top - 12'(`V_STEP);
				`KEY_LEFT:  if (m_alt) m_right = m_right + 12'(`H_STEP);
				            else m_left = m_left + 12'(`H_STEP);
				`KEY_RIGHT: if (m_alt) m_right = m_right - 12'(`H_STEP);
				            else m_left = m_left - 12'(`H_STEP);
				`KEY_ALT_L, `KEY_ALT_R:       m_alt = 1'b1;
				`KEY_ALT_L_UP, `KEY_ALT_R_UP: m_alt = 1'b0;
				default: ;
			endcase
		end
	endtask

	task automatic send_key(input logic [1:0] kind, input logic [7:0] code);
		@(posedge clk_sys);
		key <= '{level: ~key.level, kind: kind, data: code};
		apply_key_model(kind, code);
		@(posedge clk_sys);
	endtask

	task automatic check_offsets(input string name);
		logic [31:0] rd;
		wb_access(1'b0, `REG_HOFS, '0, rd);
		check_value({name, " HOFS"}, {4'h0, m_right, 4'h0, m_left}, rd);
		wb_access(1'b0, `REG_VOFS, '0, rd);
		check_value({name, " VOFS"}, {4'h0, m_bottom, 4'h0, m_top}, rd);
	endtask

	// video source, also holds the hde, vde and mode change model
	initial begin : video_gen
		geom_t      cur;
		geom_t      prev;
		bit         chk_cur;
		bit         chk_prev;
		bit         first;
		int         hde_cycles;
		int         vde_lines;
		int         vs_seen;
		int         snap_w;
		int         snap_v;
		logic [1:0] snap_res;
		chk_cur = 0;
		first = 1;
		vde_lines = 0;
		snap_w = 0;
		snap_v = 0;
		snap_res = '0;
		wait (gen_run);
		forever begin
			prev = cur;
			cur = nxt;
			chk_prev = chk_cur;
			chk_cur = trim_chk;
			frame_no++;
			for (int j = 0; j < cur.lines; j++) begin
				hde_cycles = 0;
				for (int c = 0; c < cur.len; c++) begin
					@(posedge clk_sys);
					video.hsync <= (c < cur.sync);
					video.hblank <= (c < cur.a) || (c >= cur.b);
					video.vblank <= (c >= cur.sync) ? (j < cur.vtop) : (j > 0 && j <= cur.vtop);
					video.res <= cur.res;
					@(negedge clk_sys);
					if (hde)
						hde_cycles++;
					if (c == 0 && vde)
						vde_lines++;
					if (j == 0 && c == 0) begin   // line 0 still closes the previous frame
						if (chk_prev && !first)
							check_value("vde lines", 32'(prev.lines - prev.vtop
								- int'(m_top) - int'(m_bottom)), 32'(vde_lines));
						vde_lines = 0;
					end
					if (j == cur.vtop && c == cur.sync + 1) begin
						vs_seen = first ? 1 : prev.lines - prev.vtop;
						if (snap_w != cur.b - cur.a || snap_v != vs_seen || snap_res != cur.res)
							exp_mode = exp_mode + 7'd1;
						snap_w = cur.b - cur.a;
						snap_v = vs_seen;
						snap_res = cur.res;
					end
				end
				if (chk_cur && j > 0)
					check_value("hde width", 32'(cur.b - cur.a - int'(m_left) - int'(m_right)),
						32'(hde_cycles));
			end
			first = 0;
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk_sys);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES) begin
				$display("Timeout: the run did not finish within %0d cycles", cycles);
				$display("ERRORS FOUND");
				$fatal(1, "timeout");
			end
		end
	end

	initial begin : main
		logic [31:0] rd;
		logic [31:0] wd;
		logic [7:0]  code;
		logic [1:0]  kind;
		reset = 1'b1;
		video = '0;
		key = '0;
		wb_req = '0;
		gen_run = 0;
		trim_chk = 0;
		frame_no = 0;
		{m_left, m_right, m_top, m_bottom} = '0;
		m_alt = 1'b0;
		exp_mode = '0;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;

		// measurement readback
		pick_geometry(nxt);
		gen_run = 1;
		wait_frames(3);
		wb_access(1'b0, `REG_HSIZE, '0, rd);
		check_value("hsize readback", 32'(nxt.b - nxt.a), rd);
		wb_access(1'b0, `REG_VSIZE, '0, rd);
		check_value("vsize readback", 32'(nxt.lines - nxt.vtop), rd);

		// key stepping with alt and ignored events
		repeat (40) begin
			case (rand_range(0, 9))
				0: code = `KEY_CLEAR;
				1: code = `KEY_UP;
				2: code = `KEY_DOWN;
				3: code = `KEY_LEFT;
				4: code = `KEY_RIGHT;
				5: code = `KEY_ALT_L;
				6: code = `KEY_ALT_R_UP;
				7: code = `KEY_ALT_R;
				8: code = `KEY_ALT_L_UP;
				default: code = 8'(take_bits(8));
			endcase
			kind = (take_bits(3) == 0) ? 2'(take_bits(2)) : `KEY_TYPE_KBD;
			send_key(kind, code);
			check_offsets("key step");
		end
		send_key(`KEY_TYPE_KBD, `KEY_CLEAR);
		check_offsets("key clear");

		// register writes, then trimming on settled frames
		repeat (2) begin
			pick_geometry(nxt);
			m_left = 12'(rand_range(0, 7));
			m_right = 12'(rand_range(0, 7));
			m_top = 12'(rand_range(0, 3));
			m_bottom = 12'(rand_range(0, 3));
			wd = {4'h0, m_right, 4'h0, m_left};
			wb_access(1'b1, `REG_HOFS, wd, rd);
			wd = {4'h0, m_bottom, 4'h0, m_top};
			wb_access(1'b1, `REG_VOFS, wd, rd);
			check_offsets("write");
			wb_access(1'b0, `REG_STATUS, '0, rd);
			wb_access(1'b0, `REG_HSIZE, '0, rd);
			wb_access(1'b0, `REG_VSIZE, '0, rd);
			check_offsets("after reads");
			wait_frames(3);
			trim_chk = 1;
			wait_frames(2);
			trim_chk = 0;
			wait_frames(2);
		end

		// mode changes, frame by frame
		repeat (6) begin
			case (2'(take_bits(2)))
				2'd1: nxt.b = nxt.b - rand_range(1, 3);
				2'd2: nxt.lines = rand_range(20, 40);
				2'd3: nxt.res = 2'(take_bits(2));
				default: ;
			endcase
			wait_frames(1);
			wb_access(1'b0, `REG_STATUS, '0, rd);
			check_value("mode count", 32'(exp_mode), rd);
		end
		wait_frames(2);
		wb_access(1'b0, `REG_STATUS, '0, rd);
		check_value("mode count final", 32'(exp_mode), rd);

		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- src.f
+incdir+include
verilog/video_pkg.sv
verilog/host_pkg.sv
verilog/border_ctrl.sv
verilog/line_timer.sv
verilog/frame_timer.sv
verilog/mode_monitor.sv
verilog/crop_top.sv
test/crop_assertions.sv
test/crop_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= crop_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
